// File: bench/click_trace.txt
// op arg data, one step per line, all hex
// op 1 apb write, 2 apb read, 3 frame with stop word, 4 pps, 5 wait counts, 6 end test, 0 end
1 04 00001406
1 08 00000010
1 0C 96000064
1 10 C800015E
1 00 00000005
2 04 0
2 08 0
2 0C 0
2 10 0
2 00 0
2 20 0
6 1 0
3 0 00012345
1 00 00000007
4 0 0
3 0 00012345
6 4 0
3 0 000FFFF0
3 0 0003ABCD
6 2 0
1 00 0000000B
3 0 000080B8
3 0 000002F7
3 0 00014180
3 0 000008D3
3 0 00000022
6 3 0
3 0 000080B8
3 0 00014180
5 0 0
2 14 0
2 18 0
2 1C 0
6 5 0
0 0 0

// File: bench/tb_checker.sv
`timescale 1ns/1ps
/*
 passive checker for the tdc click receiver
 mirrors registers, gc and windows from the pins and compares the outputs
*/
module tb_checker
	import tdc_pkg::*;
#(
	parameter int WINDOW_CYCLES = 200
) (
	input  logic        clk200_i,
	input  logic        gc_rst,
	input  logic        apb_psel_i,
	input  logic        apb_penable_i,
	input  logic        apb_pwrite_i,
	input  logic [7:0]  apb_paddr_i,
	input  logic [31:0] apb_pwdata_i,
	input  logic [31:0] apb_prdata_i,
	input  logic        apb_pready_i,
	input  logic        apb_pslverr_i,
	input  logic        frame_i,
	input  logic        sdi_i,
	input  logic        pps_i,
	input  logic        rec_valid_i,
	input  logic [1:0]  rec_click_i,
	input  logic [47:0] rec_gc_i,
	input  logic [31:0] rec_tdc_i,
	input  logic        count_valid_i,
	output int          err_cnt_o,
	output int          check_cnt_o
);
	localparam int ST_WAIT = 0;
	localparam int ST_DETECT = 1;
	localparam int ST_RUN = 2;

	int          err_q = 0;
	int          chk_q = 0;
	// register mirror
	logic [31:0] ctrl_m, frame_m, shift_m, gate0_m, gate1_m;
	// global counter mirror
	int          gc_st;
	logic        pps_prev;
	logic [47:0] gc_m;
	// serial frame decode
	logic        busy;
	int          pos, idx_n, stop_n;
	logic [31:0] word_acc;
	// expected record, compared one edge later
	logic        exp_rec;
	logic [1:0]  exp_click;
	logic [47:0] exp_gc;
	logic [31:0] exp_tdc;
	// window mirror
	logic        clk_pend, g0_pend, g1_pend, exp_cv, latched_m;
	int          wc;
	logic [31:0] tot, c0, c1, tot_l, c0_l, c1_l;

	assign err_cnt_o   = err_q;
	assign check_cnt_o = chk_q;

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
		chk_q++;
		if (exp !== got) begin
			err_q++;
			$display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	function automatic logic is_mapped(input logic [7:0] a);
		return (a[1:0] == 2'b00) && (a <= 8'h1C);
	endfunction

	// lo in 23:0, width in 31:24, lo inclusive
	function automatic logic in_window(input logic [31:0] m, input logic [31:0] gate);
		logic [31:0] lo;
		lo = {8'd0, gate[23:0]};
		return (m >= lo) && (m < lo + {24'd0, gate[31:24]});
	endfunction

	function automatic logic [31:0] read_value(input logic [7:0] a);
		case (a)
			8'h00:   return {23'd0, latched_m, 3'd0, ctrl_m[4:0]};
			8'h04:   return frame_m;
			8'h08:   return shift_m;
			8'h0C:   return gate0_m;
			8'h10:   return gate1_m;
			8'h14:   return tot_l;
			8'h18:   return c0_l;
			default: return c1_l;
		endcase
	endfunction

	// work out the record of a completed stop word
	task automatic predict(input logic [31:0] word);
		logic [31:0] t, f, m, p, bkt, slot;
		logic        g0, g1;
		t = word + shift_m;
		f = {18'd0, t[13:0]};
		m = f % 625;
		p = f % 1250;
		slot = ({29'd0, t[16:14]} + 1) % 8;
		bkt = 1 + f / 1250;
		if (bkt > 9)
			bkt = 9;
		g0 = in_window(m, gate0_m);
		g1 = in_window(m, gate1_m);
		exp_tdc = t;
		exp_gc = ((gc_m - 48'd12) & ~48'h3F) + 48'(8 * slot) + 48'(bkt);
		if (ctrl_m[4:2] == 3'd1) begin
			exp_rec = 1'b1;
			exp_click = 2'b11;
		end else if (ctrl_m[4:2] == 3'd2 && (g0 || g1) && p != 0) begin
			exp_rec = 1'b1;
			exp_click = {!g0, p >= 625};
		end
		// every stop while running is a click
		clk_pend = 1'b1;
		g0_pend = g0;
		g1_pend = g1;
	endtask

	always @(posedge clk200_i or posedge gc_rst) begin
		if (gc_rst) begin
			ctrl_m = '0;
			frame_m = '0;
			shift_m = '0;
			gate0_m = '0;
			gate1_m = '0;
			gc_st = ST_WAIT;
			pps_prev = 1'b0;
			gc_m = '0;
			busy = 1'b0;
			pos = 0;
			exp_rec = 1'b0;
			exp_cv = 1'b0;
			clk_pend = 1'b0;
			latched_m = 1'b0;
			wc = 0;
			{tot, c0, c1, tot_l, c0_l, c1_l} = '0;
		end else begin
			// outputs produced at the previous edge
			if (exp_rec || rec_valid_i) begin
				check_val("rec_valid_o", exp_rec, rec_valid_i);
				if (exp_rec && rec_valid_i) begin
					check_val("rec_click_o", exp_click, rec_click_i);
					check_val("rec_gc_o", exp_gc, rec_gc_i);
					check_val("rec_tdc_o", exp_tdc, rec_tdc_i);
				end
			end
			if (exp_cv || count_valid_i)
				check_val("count_valid_o", exp_cv, count_valid_i);
			// apb access phase, zero wait states
			if (apb_psel_i && apb_penable_i) begin
				check_val("apb_pready_o", 1'b1, apb_pready_i);
				check_val("apb_pslverr_o", !is_mapped(apb_paddr_i), apb_pslverr_i);
				if (!apb_pwrite_i && is_mapped(apb_paddr_i))
					check_val("apb_prdata_o", read_value(apb_paddr_i), apb_prdata_i);
			end
			// window accounting
			exp_cv = 1'b0;
			if (gc_st == ST_RUN) begin
				wc++;
				if (clk_pend) begin
					tot++;
					c0 += 32'(g0_pend);
					c1 += 32'(g1_pend);
				end
				if (wc == WINDOW_CYCLES) begin
					tot_l = tot;
					c0_l = c0;
					c1_l = c1;
					latched_m = 1'b1;
					exp_cv = 1'b1;
					{tot, c0, c1} = '0;
					wc = 0;
				end
			end else begin
				wc = 0;
				{tot, c0, c1} = '0;
			end
			clk_pend = 1'b0;
			// frame decode, record lands index + stop + 3 after frame
			exp_rec = 1'b0;
			if (!busy) begin
				if (frame_i && ctrl_m[0]) begin
					busy = 1'b1;
					pos = 0;
					word_acc = '0;
					idx_n = int'(frame_m[5:0]);
					stop_n = int'(frame_m[13:8]);
				end
			end else begin
				pos++;
				if (pos > idx_n && pos <= idx_n + stop_n)
					word_acc = {word_acc[30:0], sdi_i};
				if (pos == idx_n + stop_n + 3) begin
					busy = 1'b0;
					if (gc_st == ST_RUN)
						predict(word_acc);
				end
			end
			// gc starts on the first pps rise after start
			case (gc_st)
				ST_WAIT: if (ctrl_m[1] && !pps_i) gc_st = ST_DETECT;
				ST_DETECT: begin
					if (!ctrl_m[1]) begin
						gc_st = ST_WAIT;
					end else if (pps_i && !pps_prev) begin
						gc_st = ST_RUN;
						gc_m = '0;
					end
				end
				default: gc_m = gc_m + 48'd1;
			endcase
			pps_prev = pps_i;
			// register writes take effect at this edge
			if (apb_psel_i && apb_penable_i && apb_pwrite_i) begin
				case (apb_paddr_i)
					8'h00: ctrl_m = {27'd0, apb_pwdata_i[4:0]};
					8'h04: frame_m = apb_pwdata_i & 32'h3F3F;
					8'h08: shift_m = apb_pwdata_i & 32'h3FFF;
					8'h0C: gate0_m = apb_pwdata_i;
					8'h10: gate1_m = apb_pwdata_i;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps
/*
 testbench for the tdc click receiver
 replays the step trace over apb and the serial stop channel
*/
module tb_top
	import tdc_pkg::*;
;
	localparam int WINDOW = 200;
	localparam int FRAME_CYC = 64;

	logic              clk200_i = 1'b0;
	logic              gc_rst;
	logic              apb_psel_i, apb_penable_i, apb_pwrite_i;
	logic [7:0]        apb_paddr_i;
	logic [31:0]       apb_pwdata_i;
	logic [31:0]       apb_prdata_o;
	logic              apb_pready_o, apb_pslverr_o;
	logic              frame_i, sdi_i, pps_i;
	logic              rec_valid_o;
	logic [1:0]        rec_click_o;
	logic [GC_W-1:0]   rec_gc_o;
	logic [TDC_W-1:0]  rec_tdc_o;
	logic              count_valid_o;
	int                err_cnt, check_cnt;
	logic [31:0]       trace_mem [0:191];
	logic [31:0]       lfsr_s = 32'h203a11ed;
	int                idx_bits = 0;
	int                stop_bits = 0;
	int                limit_cycles = 0;

	always #5 clk200_i = ~clk200_i;

	tdc_click_top #(.WINDOW_CYCLES(WINDOW)) i_dut (.*);

	tb_checker #(.WINDOW_CYCLES(WINDOW)) i_checker (
		.apb_prdata_i (apb_prdata_o), .apb_pready_i (apb_pready_o),
		.apb_pslverr_i (apb_pslverr_o),
		.rec_valid_i (rec_valid_o), .rec_click_i (rec_click_o),
		.rec_gc_i (rec_gc_o), .rec_tdc_i (rec_tdc_o),
		.count_valid_i (count_valid_o), .err_cnt_o (err_cnt), .check_cnt_o (check_cnt),
		.*
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
		@(negedge clk200_i);
		apb_psel_i = 1'b1;
		apb_pwrite_i = wr;
		apb_paddr_i = addr;
		apb_pwdata_i = data;
		@(negedge clk200_i);
		apb_penable_i = 1'b1;
		@(negedge clk200_i);
		apb_psel_i = 1'b0;
		apb_penable_i = 1'b0;
		if (wr && addr == 8'h04) begin
			idx_bits = int'(data[5:0]);
			stop_bits = int'(data[13:8]);
		end
	endtask

	// index field filled from the lfsr, stop word msb first
	task automatic send_frame(input logic [31:0] word);
		@(negedge clk200_i);
		frame_i = 1'b1;
		for (int i = 0; i < idx_bits + stop_bits; i++) begin
			@(negedge clk200_i);
			frame_i = 1'b0;
			if (i < idx_bits) begin
				lfsr_s = lfsr_step(lfsr_s);
				sdi_i = lfsr_s[0];
			end else begin
				sdi_i = word[stop_bits - 1 - (i - idx_bits)];
			end
		end
		@(negedge clk200_i);
		frame_i = 1'b0;
		sdi_i = 1'b0;
		repeat (12) @(negedge clk200_i);
	endtask

	task automatic pulse_pps();
		repeat (3) @(negedge clk200_i);
		pps_i = 1'b1;
		repeat (4) @(negedge clk200_i);
		pps_i = 1'b0;
		repeat (2) @(negedge clk200_i);
	endtask

	function automatic string test_name(input int id);
		case (id)
			1: return "apb registers";
			2: return "no gate mode";
			3: return "gated mode";
			4: return "start sequence";
			default: return "window counts";
		endcase
	endfunction

	// limit follows from the trace length and the window
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk200_i);
		$display("timeout: the trace did not finish within %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int step, n_lines, err_base, tests, tests_bad;
		logic [31:0] op, arg, data;
		gc_rst = 1'b1;
		apb_psel_i = 1'b0;
		apb_penable_i = 1'b0;
		apb_pwrite_i = 1'b0;
		apb_paddr_i = '0;
		apb_pwdata_i = '0;
		frame_i = 1'b0;
		sdi_i = 1'b0;
		pps_i = 1'b0;
		tests = 0;
		tests_bad = 0;
		err_base = 0;
		$readmemh("bench/click_trace.txt", trace_mem);
		n_lines = 0;
		while (n_lines < 64 && trace_mem[3 * n_lines] != 0)
			n_lines++;
		limit_cycles = (n_lines + 1) * FRAME_CYC + 2 * WINDOW;
		repeat (3) @(posedge clk200_i);
		@(negedge clk200_i);
		gc_rst = 1'b0;
		for (step = 0; step < n_lines; step++) begin
			op = trace_mem[3 * step];
			arg = trace_mem[3 * step + 1];
			data = trace_mem[3 * step + 2];
			case (op)
				1: apb_access(1'b1, arg[7:0], data);
				2: apb_access(1'b0, arg[7:0], '0);
				3: send_frame(data);
				4: pulse_pps();
				5: begin
					@(negedge clk200_i);
					while (!count_valid_o)
						@(negedge clk200_i);
				end
				default: begin
					repeat (4) @(negedge clk200_i);
					tests++;
					if (err_cnt != err_base)
						tests_bad++;
					$display("test %0d %s finished with %0d errors", arg,
						test_name(int'(arg)), err_cnt - err_base);
					err_base = err_cnt;
				end
			endcase
		end
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, tests_bad,
			check_cnt, err_cnt);
		if (err_cnt == 0 && check_cnt > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
source/tdc_pkg.sv
source/tdc_cfg_if.sv
source/apb_cfg_regs.sv
source/stop_frame_rx.sv
source/click_timestamp.sv
source/click_rate_counters.sv
source/tdc_click_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the tdc click receiver testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_top -f compile.f -o Vtb_top
sim_out=$(./obj_dir/Vtb_top)
echo "$sim_out"

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

// File: source/apb_cfg_regs.sv
`timescale 1ns/1ps
/*
 apb slave holding the receiver configuration
 returns the latched click counts, zero wait states
*/
module apb_cfg_regs
	import tdc_pkg::*;
(
	input  logic        clk200_i,
	input  logic        gc_rst,
	input  logic        apb_psel_i,
	input  logic        apb_penable_i,
	input  logic        apb_pwrite_i,
	input  logic [7:0]  apb_paddr_i,
	input  logic [31:0] apb_pwdata_i,
	output logic [31:0] apb_prdata_o,
	output logic        apb_pready_o,
	output logic        apb_pslverr_o,
	tdc_cfg_if.cfg      cfg,
	count_if.sink       cnt
);
	logic [31:0]      gate0_r;
	logic [31:0]      gate1_r;
	logic [TDC_W-1:0] gate0_lo;
	logic [TDC_W-1:0] gate1_lo;
	logic             addr_hit;
	logic             wr_en;

	// mapped offsets
	always_comb begin
		case (apb_paddr_i)
			REG_CTRL, REG_FRAME, REG_SHIFT, REG_GATE0,
			REG_GATE1, REG_TOTAL, REG_CLICK0, REG_CLICK1: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	// no wait states, error only in access phase
	assign apb_pready_o  = 1'b1;
	assign apb_pslverr_o = apb_psel_i & apb_penable_i & ~addr_hit;
	assign wr_en         = apb_psel_i & apb_penable_i & apb_pwrite_i & addr_hit;

	always_ff @(posedge clk200_i or posedge gc_rst) begin
		if (gc_rst) begin
			cfg.enable     <= 1'b0;
			cfg.start      <= 1'b0;
			cfg.mode       <= MODE_OFF;
			cfg.index_bits <= '0;
			cfg.stop_bits  <= '0;
			cfg.tdc_shift  <= '0;
			gate0_r        <= '0;
			gate1_r        <= '0;
		end else if (wr_en) begin
			case (apb_paddr_i)
				REG_CTRL: begin
					cfg.enable <= apb_pwdata_i[0];
					cfg.start  <= apb_pwdata_i[1];
					cfg.mode   <= tdc_mode_e'(apb_pwdata_i[4:2]);
				end
				REG_FRAME: begin
					cfg.index_bits <= apb_pwdata_i[5:0];
					cfg.stop_bits  <= apb_pwdata_i[13:8];
				end
				REG_SHIFT: cfg.tdc_shift <= apb_pwdata_i[TIME_W-1:0];
				REG_GATE0: gate0_r <= apb_pwdata_i;
				REG_GATE1: gate1_r <= apb_pwdata_i;
				// count registers ignore writes
				default: ;
			endcase
		end
	end

	// gate start in 23:0, gate width in 31:24
	assign gate0_lo     = {8'd0, gate0_r[23:0]};
	assign gate1_lo     = {8'd0, gate1_r[23:0]};
	assign cfg.gate0_lo = gate0_lo;
	assign cfg.gate1_lo = gate1_lo;
	assign cfg.gate0_hi = gate0_lo + {24'd0, gate0_r[31:24]};
	assign cfg.gate1_hi = gate1_lo + {24'd0, gate1_r[31:24]};

	// read mux, latched status sits in ctrl bit 8
	always_comb begin
		case (apb_paddr_i)
			REG_CTRL:   apb_prdata_o = {23'd0, cnt.latched, 3'd0, cfg.mode, cfg.start, cfg.enable};
			REG_FRAME:  apb_prdata_o = {16'd0, 2'd0, cfg.stop_bits, 2'd0, cfg.index_bits};
			REG_SHIFT:  apb_prdata_o = {18'd0, cfg.tdc_shift};
			REG_GATE0:  apb_prdata_o = gate0_r;
			REG_GATE1:  apb_prdata_o = gate1_r;
			REG_TOTAL:  apb_prdata_o = cnt.total;
			REG_CLICK0: apb_prdata_o = cnt.click0;
			REG_CLICK1: apb_prdata_o = cnt.click1;
			default:    apb_prdata_o = '0;
		endcase
	end

endmodule

// File: source/click_rate_counters.sv
`timescale 1ns/1ps
/*
 windowed click rate counters
 total, gate 0 and gate 1 clicks, latched at each window end
*/
module click_rate_counters
	import tdc_pkg::*;
#(
	parameter int WINDOW_CYCLES = 20000000
) (
	input  logic  clk200_i,
	input  logic  gc_rst,
	input  logic  click_pulse_i,
	input  logic  in_gate0_i,
	input  logic  in_gate1_i,
	input  logic  gc_running_i,
	count_if.src  cnt,
	output logic  count_valid_o
);
	localparam int WIN_W = $clog2(WINDOW_CYCLES);

	logic [WIN_W-1:0] win_cnt;
	logic             win_end;
	logic [CNT_W-1:0] total_cnt;
	logic [CNT_W-1:0] click0_cnt;
	logic [CNT_W-1:0] click1_cnt;
	logic [CNT_W-1:0] total_next;
	logic [CNT_W-1:0] click0_next;
	logic [CNT_W-1:0] click1_next;

	// last cycle of the window
	assign win_end = gc_running_i && (win_cnt == WIN_W'(WINDOW_CYCLES - 1));

	// include a click landing on the last cycle
	assign total_next  = total_cnt + CNT_W'(click_pulse_i);
	assign click0_next = click0_cnt + CNT_W'(click_pulse_i & in_gate0_i);
	assign click1_next = click1_cnt + CNT_W'(click_pulse_i & in_gate1_i);

	always_ff @(posedge clk200_i or posedge gc_rst) begin
		if (gc_rst) begin
			win_cnt       <= '0;
			total_cnt     <= '0;
			click0_cnt    <= '0;
			click1_cnt    <= '0;
			count_valid_o <= 1'b0;
			cnt.total     <= '0;
			cnt.click0    <= '0;
			cnt.click1    <= '0;
			cnt.latched   <= 1'b0;
		end else begin
			count_valid_o <= win_end;
			if (!gc_running_i) begin
				// no window before the global counter runs
				win_cnt    <= '0;
				total_cnt  <= '0;
				click0_cnt <= '0;
				click1_cnt <= '0;
			end else if (win_end) begin
				win_cnt     <= '0;
				total_cnt   <= '0;
				click0_cnt  <= '0;
				click1_cnt  <= '0;
				cnt.total   <= total_next;
				cnt.click0  <= click0_next;
				cnt.click1  <= click1_next;
				cnt.latched <= 1'b1;
			end else begin
				win_cnt    <= win_cnt + 1'b1;
				total_cnt  <= total_next;
				click0_cnt <= click0_next;
				click1_cnt <= click1_next;
			end
		end
	end

endmodule

// File: source/click_timestamp.sv
`timescale 1ns/1ps
/*
 pps started global counter and click timestamping
 adds the tdc offset, converts to gc units, classifies against the gates
*/
module click_timestamp
	import tdc_pkg::*;
(
	input  logic             clk200_i,
	input  logic             gc_rst,
	input  logic             pps_i,
	tdc_cfg_if.user          cfg,
	input  logic             stop_valid_i,
	input  logic [TDC_W-1:0] stop_word_i,
	output logic             click_pulse_o,
	output logic             in_gate0_o,
	output logic             in_gate1_o,
	output logic             gc_running_o,
	output logic             rec_valid_o,
	output logic [1:0]       rec_click_o,
	output logic [GC_W-1:0]  rec_gc_o,
	output logic [TDC_W-1:0] rec_tdc_o
);
	typedef enum logic [1:0] {
		IDLE,
		WAIT_START,
		DETECT_PPS,
		RUN
	} gc_state_e;

	gc_state_e         state;
	logic              pps_r;
	logic [GC_W-1:0]   gc;
	logic [TDC_W-1:0]  t_sum;
	logic [TIME_W-1:0] fine;
	logic [TDC_W-1:0]  gate_mod;
	logic [TDC_W-1:0]  phase_mod;
	logic [TDC_W-1:0]  bucket_q;
	logic [2:0]        slot;
	logic [3:0]        bucket;
	logic [GC_W-1:0]   gc_base;
	logic [GC_W-1:0]   gc_stamp;
	logic              hit_g0;
	logic              hit_g1;
	logic              phase_hi;
	logic              phase_zero;
	logic              stop_run;
	logic              rec_take;
	logic [1:0]        rec_code;

	// offset corrected tdc time
	assign t_sum     = stop_word_i + TDC_W'(cfg.tdc_shift);
	assign fine      = t_sum[TIME_W-1:0];
	assign gate_mod  = TDC_W'(fine) % TDC_W'(GATE_PERIOD);
	assign phase_mod = TDC_W'(fine) % TDC_W'(PHASE_PERIOD);

	// coarse slot from bits above the fine time
	assign slot     = t_sum[TIME_W+2:TIME_W] + 3'd1;
	// 1250 unit bucket inside the slot, saturates at 9
	assign bucket_q = TDC_W'(fine) / TDC_W'(PHASE_PERIOD);
	assign bucket   = (bucket_q >= 8) ? 4'd9 : bucket_q[3:0] + 4'd1;

	// gc back off the pipeline latency, align down to 64
	assign gc_base  = gc - GC_W'(GC_LATENCY);
	assign gc_stamp = {gc_base[GC_W-1:6], 6'd0} + GC_W'(GC_PER_SLOT) * GC_W'(slot)
		+ GC_W'(bucket);

	assign hit_g0     = (gate_mod >= cfg.gate0_lo) && (gate_mod < cfg.gate0_hi);
	assign hit_g1     = (gate_mod >= cfg.gate1_lo) && (gate_mod < cfg.gate1_hi);
	assign phase_hi   = phase_mod >= TDC_W'(PHASE_PERIOD / 2);
	assign phase_zero = phase_mod == '0;

	assign stop_run     = stop_valid_i && (state == RUN);
	assign gc_running_o = state == RUN;

	// record decision, gate 0 wins on overlap
	always_comb begin
		rec_take = 1'b0;
		rec_code = 2'b11;
		case (cfg.mode)
			MODE_NO_GATE: rec_take = 1'b1;
			MODE_GATED: begin
				rec_take = (hit_g0 | hit_g1) & ~phase_zero;
				rec_code = {~hit_g0, phase_hi};
			end
			default: rec_take = 1'b0;
		endcase
	end

	always_ff @(posedge clk200_i or posedge gc_rst) begin
		if (gc_rst) begin
			state         <= IDLE;
			pps_r         <= 1'b0;
			gc            <= '0;
			rec_valid_o   <= 1'b0;
			click_pulse_o <= 1'b0;
			in_gate0_o    <= 1'b0;
			in_gate1_o    <= 1'b0;
		end else begin
			pps_r <= pps_i;
			case (state)
				IDLE: state <= WAIT_START;
				WAIT_START: begin
					// arm only while pps is low
					if (cfg.start && !pps_i)
						state <= DETECT_PPS;
				end
				DETECT_PPS: begin
					if (!cfg.start) begin
						state <= WAIT_START;
					end else if (pps_i && !pps_r) begin
						state <= RUN;
						gc    <= '0;
					end
				end
				RUN: gc <= gc + 1'b1;
				default: state <= IDLE;
			endcase
			// one cycle after stop_valid
			rec_valid_o   <= stop_run & rec_take;
			click_pulse_o <= stop_run;
			in_gate0_o    <= stop_run & hit_g0;
			in_gate1_o    <= stop_run & hit_g1;
		end
	end

	// record payload, stamped with gc of the stop cycle
	always_ff @(posedge clk200_i) begin
		if (stop_run) begin
			rec_click_o <= rec_code;
			rec_gc_o    <= gc_stamp;
			rec_tdc_o   <= t_sum;
		end
	end

endmodule

// File: source/stop_frame_rx.sv
`timescale 1ns/1ps
/*
 serial frame receiver for the tdc stop channel
 skips the index field and shifts in one stop word per frame
*/
module stop_frame_rx
	import tdc_pkg::*;
(
	input  logic             clk200_i,
	input  logic             gc_rst,
	input  logic             frame_i,
	input  logic             sdi_i,
	tdc_cfg_if.user          cfg,
	output logic             stop_valid_o,
	output logic [TDC_W-1:0] stop_word_o
);
	typedef enum logic [2:0] {
		IDLE,
		WAIT_FRAME,
		SKIP_INDEX,
		SHIFT_STOP,
		HOLD
	} rx_state_e;

	rx_state_e        state;
	logic [6:0]       bit_cnt;
	logic             sdi_r;
	logic             sdi_2r;
	logic [TDC_W-1:0] shreg;
	logic [TDC_W-1:0] shreg_next;
	logic             last_bit;

	// first index bit is on sdi one clock after frame is seen
	// sdi is two clocks late through sdi_2r, hence index_bits + 1 skip steps
	assign shreg_next = {shreg[TDC_W-2:0], sdi_2r};
	assign last_bit   = (state == SHIFT_STOP) && (bit_cnt == '0);

	always_ff @(posedge clk200_i or posedge gc_rst) begin
		if (gc_rst) begin
			state        <= IDLE;
			bit_cnt      <= '0;
			stop_valid_o <= 1'b0;
		end else begin
			stop_valid_o <= 1'b0;
			case (state)
				IDLE: begin
					if (cfg.enable)
						state <= WAIT_FRAME;
				end
				WAIT_FRAME: begin
					if (!cfg.enable) begin
						state <= IDLE;
					end else if (frame_i) begin
						state   <= SKIP_INDEX;
						bit_cnt <= {1'b0, cfg.index_bits} + 7'd1;
					end
				end
				SKIP_INDEX: begin
					if (bit_cnt == '0) begin
						state   <= SHIFT_STOP;
						bit_cnt <= {1'b0, cfg.stop_bits} - 7'd1;
					end else begin
						bit_cnt <= bit_cnt - 7'd1;
					end
				end
				SHIFT_STOP: begin
					if (bit_cnt == '0) begin
						// word complete, start hold-off
						state        <= HOLD;
						stop_valid_o <= 1'b1;
						bit_cnt      <= 7'(STRETCH_CYCLES - 1);
					end else begin
						bit_cnt <= bit_cnt - 7'd1;
					end
				end
				HOLD: begin
					// frame_i ignored here
					if (bit_cnt == '0)
						state <= WAIT_FRAME;
					else
						bit_cnt <= bit_cnt - 7'd1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// serial data path, msb first and right aligned
	always_ff @(posedge clk200_i) begin
		sdi_r  <= sdi_i;
		sdi_2r <= sdi_r;
		if (state == WAIT_FRAME)
			shreg <= '0;
		else if (state == SHIFT_STOP)
			shreg <= shreg_next;
		if (last_bit)
			stop_word_o <= shreg_next;
	end

endmodule

// File: source/tdc_cfg_if.sv
`timescale 1ns/1ps
/*
 configuration and count buses of the tdc click receiver
*/

// register block drives, receiver and timestamp stage read
interface tdc_cfg_if
	import tdc_pkg::*;
();
	logic              enable;
	logic              start;
	tdc_mode_e         mode;
	logic [5:0]        index_bits;
	logic [5:0]        stop_bits;
	logic [TIME_W-1:0] tdc_shift;
	// gate windows, lo inclusive and hi exclusive
	logic [TDC_W-1:0]  gate0_lo;
	logic [TDC_W-1:0]  gate0_hi;
	logic [TDC_W-1:0]  gate1_lo;
	logic [TDC_W-1:0]  gate1_hi;

	modport cfg (
		output enable, start, mode, index_bits, stop_bits, tdc_shift,
		output gate0_lo, gate0_hi, gate1_lo, gate1_hi
	);

	// consumer side
	modport user (
		input enable, start, mode, index_bits, stop_bits, tdc_shift,
		input gate0_lo, gate0_hi, gate1_lo, gate1_hi
	);
endinterface

// latched window counts towards the register block
interface count_if
	import tdc_pkg::*;
();
	logic [CNT_W-1:0] total;
	logic [CNT_W-1:0] click0;
	logic [CNT_W-1:0] click1;
	// set once the first window has closed
	logic             latched;

	modport src (output total, click0, click1, latched);
	modport sink (input total, click0, click1, latched);
endinterface

// File: source/tdc_click_top.sv
`timescale 1ns/1ps
/*
 tdc click receiver top level
 apb registers, stop frame receiver, timestamping and rate counters
*/
module tdc_click_top
	import tdc_pkg::*;
#(
	parameter int WINDOW_CYCLES = 20000000
) (
	input  logic             clk200_i,
	input  logic             gc_rst,
	// apb slave
	input  logic             apb_psel_i,
	input  logic             apb_penable_i,
	input  logic             apb_pwrite_i,
	input  logic [7:0]       apb_paddr_i,
	input  logic [31:0]      apb_pwdata_i,
	output logic [31:0]      apb_prdata_o,
	output logic             apb_pready_o,
	output logic             apb_pslverr_o,
	// tdc serial stop channel
	input  logic             frame_i,
	input  logic             sdi_i,
	input  logic             pps_i,
	// click records
	output logic             rec_valid_o,
	output logic [1:0]       rec_click_o,
	output logic [GC_W-1:0]  rec_gc_o,
	output logic [TDC_W-1:0] rec_tdc_o,
	output logic             count_valid_o
);
	tdc_cfg_if cfg_bus ();
	count_if   cnt_bus ();

	logic             stop_valid;
	logic [TDC_W-1:0] stop_word;
	logic             click_pulse;
	logic             in_gate0;
	logic             in_gate1;
	logic             gc_running;

	apb_cfg_regs i_apb_regs (
		.clk200_i      (clk200_i),
		.gc_rst        (gc_rst),
		.apb_psel_i    (apb_psel_i),
		.apb_penable_i (apb_penable_i),
		.apb_pwrite_i  (apb_pwrite_i),
		.apb_paddr_i   (apb_paddr_i),
		.apb_pwdata_i  (apb_pwdata_i),
		.apb_prdata_o  (apb_prdata_o),
		.apb_pready_o  (apb_pready_o),
		.apb_pslverr_o (apb_pslverr_o),
		.cfg           (cfg_bus.cfg),
		.cnt           (cnt_bus.sink)
	);

	stop_frame_rx i_frame_rx (
		.clk200_i     (clk200_i),
		.gc_rst       (gc_rst),
		.frame_i      (frame_i),
		.sdi_i        (sdi_i),
		.cfg          (cfg_bus.user),
		.stop_valid_o (stop_valid),
		.stop_word_o  (stop_word)
	);

	click_timestamp i_timestamp (
		.clk200_i      (clk200_i),
		.gc_rst        (gc_rst),
		.pps_i         (pps_i),
		.cfg           (cfg_bus.user),
		.stop_valid_i  (stop_valid),
		.stop_word_i   (stop_word),
		.click_pulse_o (click_pulse),
		.in_gate0_o    (in_gate0),
		.in_gate1_o    (in_gate1),
		.gc_running_o  (gc_running),
		.rec_valid_o   (rec_valid_o),
		.rec_click_o   (rec_click_o),
		.rec_gc_o      (rec_gc_o),
		.rec_tdc_o     (rec_tdc_o)
	);

	click_rate_counters #(
		.WINDOW_CYCLES (WINDOW_CYCLES)
	) i_rate_cnt (
		.clk200_i      (clk200_i),
		.gc_rst        (gc_rst),
		.click_pulse_i (click_pulse),
		.in_gate0_i    (in_gate0),
		.in_gate1_i    (in_gate1),
		.gc_running_i  (gc_running),
		.cnt           (cnt_bus.src),
		.count_valid_o (count_valid_o)
	);

endmodule

// File: source/tdc_pkg.sv
/*
 tdc click receiver shared definitions
 widths, apb register map, mode encoding and timing constants
*/
package tdc_pkg;

	// datapath widths
	localparam int GC_W   = 48;
	localparam int TDC_W  = 32;
	localparam int TIME_W = 14;
	localparam int CNT_W  = 32;

	// tdc time bases, in tdc units
	localparam int GATE_PERIOD  = 625;
	localparam int PHASE_PERIOD = 1250;

	// global counter alignment
	localparam int GC_PER_SLOT = 8;
	localparam int GC_LATENCY  = 12;

	// receiver hold-off after each stop word
	localparam int STRETCH_CYCLES = 4;

	// apb register offsets, one word apart
	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_FRAME  = 8'h04;
	localparam logic [7:0] REG_SHIFT  = 8'h08;
	localparam logic [7:0] REG_GATE0  = 8'h0C;
	localparam logic [7:0] REG_GATE1  = 8'h10;
	localparam logic [7:0] REG_TOTAL  = 8'h14;
	localparam logic [7:0] REG_CLICK0 = 8'h18;
	localparam logic [7:0] REG_CLICK1 = 8'h1C;

	// record mode, other codes give no records
	typedef enum logic [2:0] {
		MODE_OFF     = 3'd0,
		MODE_NO_GATE = 3'd1,
		MODE_GATED   = 3'd2
	} tdc_mode_e;

endpackage
